// ==== rx_settings.svh ====
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

// number of words in the receive buffer, also the starting credit count.
// must be a power of two, 2 or more.
`define RX_DEPTH 8

// width of one link word.
`define RX_DATA_W 32

// cycles after reset release before the processor side is served.
`define RX_HOLD_CYCLES 16

`endif

// ==== link_pkg.sv ====
package link_pkg;

  // tag stored with every buffered word.
  typedef enum logic [1:0]
  {
    WK_NONE  = 2'd0,  // no word, seen only in responses.
    WK_DATA  = 2'd1,
    WK_LAST  = 2'd2,  // final word of a frame.
    WK_ABORT = 2'd3   // word arrived with the error mark.
  } word_kind;

  // receiver position relative to frame boundaries.
  typedef enum logic
  {
    RS_IDLE  = 1'b0,
    RS_FRAME = 1'b1
  } rx_state;

endpackage

// ==== host_pkg.sv ====
package host_pkg;

  // single-word commands issued by the processor side.
  typedef enum logic [1:0]
  {
    OP_NOP         = 2'd0,
    OP_READ_WORD   = 2'd1,  // pop and return the head word.
    OP_READ_STATUS = 2'd2,  // frame statistics.
    OP_ACK_ERROR   = 2'd3
  } host_op;

  // host port state around the reset hold.
  typedef enum logic
  {
    PS_HOLD = 1'b0,
    PS_RUN  = 1'b1
  } port_state;

endpackage

// ==== frame_receiver.sv ====
`timescale 1ns/1ps
`include "rx_settings.svh"

module frame_receiver
(
  input  logic                  CPU_CLK,
  input  logic                  RST,
  input  logic                  rx_valid,
  input  logic [`RX_DATA_W-1:0] rx_data,
  input  logic                  rx_last,
  input  logic                  rx_err,
  output logic                  rx_ready,
  output logic                  push,
  output logic [`RX_DATA_W-1:0] push_data,
  output link_pkg::word_kind    push_kind,
  input  logic                  credit
);

  localparam int CNT_W = $clog2(`RX_DEPTH) + 1;

  logic [CNT_W-1:0]   credits;
  logic               accept;
  logic               frame_end;
  link_pkg::word_kind in_kind;
  link_pkg::rx_state  state;
  link_pkg::rx_state  state_next;

  assign rx_ready  = (credits != '0);  // one credit per free buffer slot.
  assign accept    = rx_valid && rx_ready;
  assign frame_end = rx_last || rx_err;

  always_comb
  begin
    if (rx_err)
      in_kind = link_pkg::WK_ABORT;  // the error mark wins over the end mark.
    else if (rx_last)
      in_kind = link_pkg::WK_LAST;
    else
      in_kind = link_pkg::WK_DATA;
  end

  // credit count, taken by each accepted word and given back by the buffer.
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      credits <= CNT_W'(`RX_DEPTH);
    else
    begin
      case ({accept, credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // a take and a return cancel out.
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      push <= 1'b0;
    else
      push <= accept;
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      push_data <= rx_data;
      push_kind <= in_kind;
    end
  end

  always_comb
  begin
    state_next = state;
    case (state)
      link_pkg::RS_IDLE:
        if (accept && !frame_end)
          state_next = link_pkg::RS_FRAME;  // a one-word frame never leaves idle.
      link_pkg::RS_FRAME:
        if (accept && frame_end)
          state_next = link_pkg::RS_IDLE;
      default:
        state_next = link_pkg::RS_IDLE;
    endcase
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      state <= link_pkg::RS_IDLE;
    else
      state <= state_next;
  end

endmodule

// ==== lsab_buffer.sv ====
`timescale 1ns/1ps
`include "rx_settings.svh"

module lsab_buffer
(
  input  logic                  CPU_CLK,
  input  logic                  RST,
  input  logic                  push,
  input  logic [`RX_DATA_W-1:0] push_data,
  input  link_pkg::word_kind    push_kind,
  input  logic                  pop,
  output logic                  head_valid,
  output logic [`RX_DATA_W-1:0] head_data,
  output link_pkg::word_kind    head_kind,
  output logic                  credit
);

  localparam int PTR_W = $clog2(`RX_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [`RX_DATA_W-1:0] mem_data [`RX_DEPTH];
  link_pkg::word_kind    mem_kind [`RX_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [PTR_W-1:0]      rd_ptr_next;
  logic [CNT_W-1:0]      occupancy;
  logic [CNT_W-1:0]      occupancy_next;
  logic                  bypass;

  assign rd_ptr_next    = rd_ptr + PTR_W'(pop);
  assign occupancy_next = occupancy + CNT_W'(push) - CNT_W'(pop);
  // the incoming word becomes the head when nothing else is left in front of it.
  assign bypass         = push && (occupancy == CNT_W'(pop));

  always_ff @(posedge CPU_CLK)
  begin
    if (push)
    begin
      mem_data[wr_ptr] <= push_data;
      mem_kind[wr_ptr] <= push_kind;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      occupancy  <= '0;
      head_valid <= 1'b0;
      head_kind  <= link_pkg::WK_NONE;
      credit     <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // pointers wrap on their own width.
      rd_ptr     <= rd_ptr_next;
      occupancy  <= occupancy_next;
      head_valid <= (occupancy_next != '0);
      head_kind  <= bypass ? push_kind : mem_kind[rd_ptr_next];
      credit     <= pop;  // each freed slot goes back to the receiver.
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (bypass)
      head_data <= push_data;
    else
      head_data <= mem_data[rd_ptr_next];
  end

endmodule

// ==== host_port.sv ====
`timescale 1ns/1ps
`include "rx_settings.svh"

module host_port
(
  input  logic                  CPU_CLK,
  input  logic                  RST,
  input  logic                  head_valid,
  input  logic [`RX_DATA_W-1:0] head_data,
  input  link_pkg::word_kind    head_kind,
  output logic                  pop,
  input  logic                  cmd_valid,
  input  host_pkg::host_op      cmd_op,
  output logic                  cpu_ready,
  output logic                  rsp_valid,
  output logic [`RX_DATA_W-1:0] rsp_data,
  output link_pkg::word_kind    rsp_kind,
  output logic                  irq,
  output logic                  err
);

  localparam int HOLD_W = $clog2(`RX_HOLD_CYCLES + 1);
  localparam int STAT_W = 16;

  host_pkg::port_state state;
  logic [HOLD_W-1:0]   hold_cnt;
  logic                take;
  logic [STAT_W-1:0]   frames_done;
  logic [STAT_W-1:0]   run_len;
  logic [STAT_W-1:0]   last_frame_len;

  assign cpu_ready = (state == host_pkg::PS_RUN);
  assign take      = cmd_valid && cpu_ready;
  assign pop       = take && (cmd_op == host_pkg::OP_READ_WORD) && head_valid;
  assign irq       = cpu_ready && head_valid;

  // processor side is kept off for a fixed time after reset release.
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state    <= host_pkg::PS_HOLD;
      hold_cnt <= '0;
    end
    else if (state == host_pkg::PS_HOLD)
    begin
      if (hold_cnt == HOLD_W'(`RX_HOLD_CYCLES - 1))
        state <= host_pkg::PS_RUN;
      else
        hold_cnt <= hold_cnt + 1'b1;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      rsp_valid <= 1'b0;
      rsp_kind  <= link_pkg::WK_NONE;
    end
    else
    begin
      rsp_valid <= take && (cmd_op != host_pkg::OP_NOP);
      rsp_kind  <= pop ? head_kind : link_pkg::WK_NONE;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    case (cmd_op)
      host_pkg::OP_READ_WORD:
        rsp_data <= head_valid ? head_data : '0;
      host_pkg::OP_READ_STATUS:
        rsp_data <= `RX_DATA_W'({frames_done, last_frame_len});
      default:
        rsp_data <= '0;
    endcase
  end

  // frame statistics follow the words as they leave the buffer.
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      frames_done    <= '0;
      run_len        <= '0;
      last_frame_len <= '0;
    end
    else if (pop)
    begin
      case (head_kind)
        link_pkg::WK_LAST:
        begin
          frames_done    <= frames_done + 1'b1;
          last_frame_len <= run_len + 1'b1;  // the closing word counts too.
          run_len        <= '0;
        end
        link_pkg::WK_ABORT: run_len <= '0;
        default:            run_len <= run_len + 1'b1;
      endcase
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      err <= 1'b0;
    else if (pop && (head_kind == link_pkg::WK_ABORT))
      err <= 1'b1;
    else if (take && (cmd_op == host_pkg::OP_ACK_ERROR))
      err <= 1'b0;
  end

endmodule

// ==== rx_chip.sv ====
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_chip
(
  input  logic                  CPU_CLK,
  input  logic                  RST,
  input  logic                  rx_valid,
  input  logic [`RX_DATA_W-1:0] rx_data,
  input  logic                  rx_last,
  input  logic                  rx_err,
  output logic                  rx_ready,
  input  logic                  cmd_valid,
  input  host_pkg::host_op      cmd_op,
  output logic                  cpu_ready,
  output logic                  rsp_valid,
  output logic [`RX_DATA_W-1:0] rsp_data,
  output link_pkg::word_kind    rsp_kind,
  output logic                  irq,
  output logic                  err
);

  logic                  push;
  logic [`RX_DATA_W-1:0] push_data;
  link_pkg::word_kind    push_kind;
  logic                  credit;
  logic                  pop;
  logic                  head_valid;
  logic [`RX_DATA_W-1:0] head_data;
  link_pkg::word_kind    head_kind;

  frame_receiver u_receiver
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_last(rx_last), .rx_err(rx_err),
    .rx_ready(rx_ready),
    .push(push), .push_data(push_data), .push_kind(push_kind),
    .credit(credit)
  );

  lsab_buffer u_buffer
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .push(push), .push_data(push_data), .push_kind(push_kind),
    .pop(pop),
    .head_valid(head_valid), .head_data(head_data), .head_kind(head_kind),
    .credit(credit)
  );

  host_port u_host
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .head_valid(head_valid), .head_data(head_data), .head_kind(head_kind), .pop(pop),
    .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cpu_ready(cpu_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_kind(rsp_kind),
    .irq(irq), .err(err)
  );

endmodule

// ==== rx_chip_props.sv ====
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_chip_props
(
  input logic             CPU_CLK,
  input logic             RST,
  input logic             push,
  input logic             pop,
  input logic             credit,
  input logic             head_valid,
  input logic             cmd_valid,
  input host_pkg::host_op cmd_op,
  input logic             cpu_ready,
  input logic             rsp_valid,
  input logic             irq
);

  localparam int CNT_W = $clog2(`RX_DEPTH) + 1;

  logic [CNT_W-1:0] occupancy;  // words in the buffer, rebuilt from push and pop.

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
      occupancy <= '0;
    else
      occupancy <= occupancy + CNT_W'(push) - CNT_W'(pop);
  end

  no_overflow: assert property (@(posedge CPU_CLK) disable iff (!RST)
    push |-> (occupancy != CNT_W'(`RX_DEPTH)))
    else $error("push into a full buffer");

  credit_after_pop: assert property (@(posedge CPU_CLK) disable iff (!RST)
    pop |=> credit)
    else $error("no credit pulse one cycle after a pop");

  rsp_after_cmd: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (cmd_valid && cpu_ready && (cmd_op != host_pkg::OP_NOP)) |=> rsp_valid)
    else $error("no response one cycle after a taken command");

  pop_with_head: assert property (@(posedge CPU_CLK) disable iff (!RST)
    pop |-> head_valid)
    else $error("pop without a head word");

  irq_needs_ready: assert property (@(posedge CPU_CLK) disable iff (!RST)
    !(irq && !cpu_ready))
    else $error("irq raised while the host port is held");

endmodule

bind rx_chip rx_chip_props u_props
(
  .CPU_CLK(CPU_CLK), .RST(RST), .push(push), .pop(pop), .credit(credit),
  .head_valid(head_valid), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
  .cpu_ready(cpu_ready), .rsp_valid(rsp_valid), .irq(irq)
);

// ==== tb_rx_chip.sv ====
`timescale 1ns/1ps
`include "rx_settings.svh"

module tb_rx_chip;

  localparam int TIMEOUT = 200;  // cycles that any single wait may take.

  logic                  CPU_CLK;
  logic                  RST;
  logic                  rx_valid;
  logic [`RX_DATA_W-1:0] rx_data;
  logic                  rx_last;
  logic                  rx_err;
  logic                  rx_ready;
  logic                  cmd_valid;
  host_pkg::host_op      cmd_op;
  logic                  cpu_ready;
  logic                  rsp_valid;
  logic [`RX_DATA_W-1:0] rsp_data;
  link_pkg::word_kind    rsp_kind;
  logic                  irq;
  logic                  err;

  logic [`RX_DATA_W-1:0] sent_data [$];  // scoreboard of accepted link words.
  link_pkg::word_kind    sent_kind [$];
  logic [15:0]           frames_done;  // status model, advanced on every read.
  logic [15:0]           run_len;
  logic [15:0]           last_len;
  int                    errors;
  int                    tests;
  int                    test_errors;
  int                    seed;
  bit                    finished;

  rx_chip u_dut
  (
    .CPU_CLK(CPU_CLK), .RST(RST),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_last(rx_last), .rx_err(rx_err),
    .rx_ready(rx_ready), .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cpu_ready(cpu_ready),
    .rsp_valid(rsp_valid), .rsp_data(rsp_data), .rsp_kind(rsp_kind), .irq(irq), .err(err)
  );

  always #2 CPU_CLK = ~CPU_CLK;

  task automatic note_failure(string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic value_error(string name, logic [31:0] expected, logic [31:0] actual);
    errors++;
    $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
  endtask

  task automatic expect_bit(string name, logic expected, logic actual);
    assert (actual === expected)
      else value_error(name, 32'(expected), 32'(actual));
  endtask

  task automatic finish_run();
    finished = 1'b1;
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  task automatic timeout_fail(string what);
    if (!finished)
    begin
      errors++;
      $display("timeout while waiting for %s", what);
      finish_run();
    end
  endtask

  task automatic end_test(string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_errors) ? "ok" : "failed");
    test_errors = errors;
  endtask

  task automatic send_word(logic [`RX_DATA_W-1:0] data, bit last, bit abort);
    int cnt;
    rx_valid = 1'b1;
    rx_data  = data;
    rx_last  = last;
    rx_err   = abort;
    for (cnt = 0; cnt < TIMEOUT && !rx_ready; cnt++)
      @(negedge CPU_CLK);
    if (!rx_ready)
      timeout_fail("rx_ready");
    sent_data.push_back(data);
    sent_kind.push_back(abort ? link_pkg::WK_ABORT
                              : (last ? link_pkg::WK_LAST : link_pkg::WK_DATA));
    @(negedge CPU_CLK);  // the word moves on the rising edge in between.
    rx_valid = 1'b0;
    rx_last  = 1'b0;
    rx_err   = 1'b0;
  endtask

  task automatic issue_cmd(host_pkg::host_op op, output logic [`RX_DATA_W-1:0] data,
                           output link_pkg::word_kind kind);
    int cnt;
    for (cnt = 0; cnt < TIMEOUT && !cpu_ready; cnt++)
      @(negedge CPU_CLK);
    if (!cpu_ready)
      timeout_fail("cpu_ready");
    cmd_valid = 1'b1;
    cmd_op    = op;
    @(negedge CPU_CLK);
    cmd_valid = 1'b0;
    cmd_op    = host_pkg::OP_NOP;
    assert (rsp_valid == (op != host_pkg::OP_NOP))
      else value_error("rsp_valid", 32'(op != host_pkg::OP_NOP), 32'(rsp_valid));
    data = rsp_data;
    kind = rsp_kind;
  endtask

  task automatic read_check(output link_pkg::word_kind kind);
    logic [`RX_DATA_W-1:0] data;
    logic [`RX_DATA_W-1:0] exp_data;
    link_pkg::word_kind    exp_kind;
    int                    cnt;
    for (cnt = 0; cnt < TIMEOUT && !irq; cnt++)
      @(negedge CPU_CLK);
    if (!irq)
      timeout_fail("irq");
    issue_cmd(host_pkg::OP_READ_WORD, data, kind);
    if (sent_data.size() == 0)
      note_failure("a word was read that was never sent");
    else
    begin
      exp_data = sent_data.pop_front();
      exp_kind = sent_kind.pop_front();
      assert (data == exp_data)
        else value_error("rsp_data", exp_data, data);
      assert (kind == exp_kind)
        else value_error("rsp_kind", 32'(exp_kind), 32'(kind));
      case (exp_kind)
        link_pkg::WK_LAST:
        begin
          frames_done = frames_done + 16'd1;
          last_len    = run_len + 16'd1;  // the closing word is part of the frame.
          run_len     = 16'd0;
        end
        link_pkg::WK_ABORT:
        begin
          run_len = 16'd0;
          expect_bit("err", 1'b1, err);  // the flag rises as the aborted word leaves.
        end
        default:            run_len = run_len + 16'd1;
      endcase
    end
  endtask

  task automatic check_status();
    logic [`RX_DATA_W-1:0] data;
    link_pkg::word_kind    kind;
    issue_cmd(host_pkg::OP_READ_STATUS, data, kind);
    assert (data == {frames_done, last_len})
      else value_error("rsp_data", {frames_done, last_len}, data);
    assert (kind == link_pkg::WK_NONE)
      else value_error("rsp_kind", 32'(link_pkg::WK_NONE), 32'(kind));
  endtask

  ready_holds: assert property (@(posedge CPU_CLK) disable iff (!RST) cpu_ready |=> cpu_ready)
    else note_failure("cpu_ready fell after the reset hold ended");
  err_holds: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (err && !(cmd_valid && cpu_ready && cmd_op == host_pkg::OP_ACK_ERROR)) |=> err)
    else note_failure("err cleared without an acknowledge");
  ack_clears: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (cmd_valid && cpu_ready && cmd_op == host_pkg::OP_ACK_ERROR) |=> !err)
    else note_failure("err still set after an acknowledge");

  initial
  begin
    logic [`RX_DATA_W-1:0] data;
    link_pkg::word_kind    kind;
    int                    lens [$];
    bit                    aborts [$];
    int                    gaps [$];
    int                    total;
    int                    i;
    int                    j;
    int                    k;
    CPU_CLK     = 1'b0;
    RST         = 1'b0;
    rx_valid    = 1'b0;
    rx_data     = '0;
    rx_last     = 1'b0;
    rx_err      = 1'b0;
    cmd_valid   = 1'b0;
    cmd_op      = host_pkg::OP_NOP;
    frames_done = 16'd0;
    run_len     = 16'd0;
    last_len    = 16'd0;
    seed        = 32'hc3788227;
    repeat (5) @(negedge CPU_CLK);
    expect_bit("cpu_ready", 1'b0, cpu_ready);
    expect_bit("rx_ready", 1'b1, rx_ready);
    RST = 1'b1;
    send_word($random(seed), 1'b1, 1'b1);  // this word waits in the buffer during the hold.
    for (i = 1; i <= `RX_HOLD_CYCLES; i++)
    begin
      if (i > 1)
        @(negedge CPU_CLK);
      expect_bit("cpu_ready", i == `RX_HOLD_CYCLES, cpu_ready);
      expect_bit("irq", i == `RX_HOLD_CYCLES, irq);
      expect_bit("err", 1'b0, err);
      expect_bit("rx_ready", 1'b1, rx_ready);
    end
    read_check(kind);
    issue_cmd(host_pkg::OP_ACK_ERROR, data, kind);
    end_test("reset hold");

    for (i = 0; i < 5; i++)
      send_word($random(seed), i == 4, 1'b0);
    for (i = 0; i < 5; i++)
      read_check(kind);
    check_status();
    end_test("single frame");

    for (i = 0; i < `RX_DEPTH; i++)
    begin
      expect_bit("rx_ready", 1'b1, rx_ready);
      send_word($random(seed), 1'b0, 1'b0);
    end
    for (i = 0; i < 3; i++)
    begin
      expect_bit("rx_ready", 1'b0, rx_ready);  // no credits left while reads pause.
      @(negedge CPU_CLK);
    end
    fork
      begin
        send_word($random(seed), 1'b0, 1'b0);
        send_word($random(seed), 1'b1, 1'b0);
      end
      begin
        for (k = 0; k < `RX_DEPTH + 2; k++)
          read_check(kind);
      end
    join
    check_status();
    end_test("back-pressure");

    send_word($random(seed), 1'b0, 1'b0);
    send_word($random(seed), 1'b0, 1'b0);
    send_word($random(seed), 1'b0, 1'b1);
    for (i = 0; i < 3; i++)
      read_check(kind);
    expect_bit("err", 1'b1, err);
    issue_cmd(host_pkg::OP_NOP, data, kind);
    expect_bit("err", 1'b1, err);
    check_status();
    issue_cmd(host_pkg::OP_ACK_ERROR, data, kind);
    assert (kind == link_pkg::WK_NONE)
      else value_error("rsp_kind", 32'(link_pkg::WK_NONE), 32'(kind));
    expect_bit("err", 1'b0, err);
    end_test("abort");

    expect_bit("irq", 1'b0, irq);
    issue_cmd(host_pkg::OP_READ_WORD, data, kind);
    assert (data == '0)
      else value_error("rsp_data", 32'd0, data);
    assert (kind == link_pkg::WK_NONE)
      else value_error("rsp_kind", 32'(link_pkg::WK_NONE), 32'(kind));
    end_test("empty read");

    total = 0;
    for (i = 0; i < 12; i++)
    begin
      lens.push_back(1 + int'($unsigned($random(seed)) % 6));
      aborts.push_back(($unsigned($random(seed)) % 5) == 0);
      total += lens[i];
    end
    for (i = 0; i < total; i++)
      gaps.push_back(int'($unsigned($random(seed)) % 4));
    fork
      begin
        for (i = 0; i < 12; i++)
        begin
          for (j = 0; j < lens[i]; j++)
            send_word($random(seed), j == lens[i] - 1, j == lens[i] - 1 && aborts[i]);
        end
      end
      begin
        for (k = 0; k < total; k++)
        begin
          repeat (gaps[k]) @(negedge CPU_CLK);
          read_check(kind);
          if (kind == link_pkg::WK_LAST)
            check_status();
        end
      end
    join
    if (err)
      issue_cmd(host_pkg::OP_ACK_ERROR, data, kind);
    check_status();
    if (sent_data.size() != 0)
      note_failure("sent words were never read back");
    end_test("random traffic");
    finish_run();
  end

endmodule

// ==== sim.f ====
+incdir+.
link_pkg.sv
host_pkg.sv
frame_receiver.sv
lsab_buffer.sv
host_port.sv
rx_chip.sv
rx_chip_props.sv
tb_rx_chip.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rx_chip
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
